//--- src/cpuPkg.sv
package cpuPkg;

    // Data and address word.
    typedef logic [31:0] word_t;

    // Register number, bit 5 selects the float bank.
    typedef logic [5:0] regAddr_t;

    // Raw jump field or sign-extended 16-bit field.
    typedef logic [25:0] immediate_t;

    typedef logic [5:0] funct_t;
    typedef logic [5:0] opcode_t;
    typedef logic [1:0] format_t;

    // R-format category, instruction bits 5:4.
    typedef logic [1:0] category_t;

    // Instruction formats from opcode bits 31:30.
    localparam format_t RegisterFormat = 2'b00;
    localparam format_t JumpFormat     = 2'b01;

    // R-format categories.
    localparam category_t Arithmetic = 2'b00;
    localparam category_t Compare    = 2'b01;
    localparam category_t Float      = 2'b10;
    localparam category_t Vector     = 2'b11;

    // Opcodes that need their own handling.
    localparam opcode_t LoadCode          = 6'b101000;
    localparam opcode_t LoadFloatCode     = 6'b101001;
    localparam opcode_t StoreCode         = 6'b101010;
    localparam opcode_t StoreFloatCode    = 6'b101011;
    localparam opcode_t JumpRegCode       = 6'b101100;
    localparam opcode_t BranchZeroCode    = 6'b101101;
    localparam opcode_t BranchNotZeroCode = 6'b101110;
    localparam opcode_t JalCode           = 6'b101111;
    localparam opcode_t JumpCode          = 6'b010000;

    // Both immediate formats have the top format bit set.
    function automatic logic isImmediateFormat(input format_t format);
        return format[1];
    endfunction

    // Float register number from a 5-bit field.
    function automatic regAddr_t floatReg(input logic [4:0] field);
        return {1'b1, field};
    endfunction

    // Integer register number from a 5-bit field.
    function automatic regAddr_t intReg(input logic [4:0] field);
        return {1'b0, field};
    endfunction

endpackage

//--- src/decodeBus.sv
`timescale 1ns/1ps

interface decodeBus;
    import cpuPkg::*;

    regAddr_t   sourceReg1;
    regAddr_t   sourceReg2;
    regAddr_t   destReg;
    immediate_t immediate;
    logic       immediateActive;
    funct_t     functionCode;
    logic       isJal;
    logic       relativeJump;
    logic       absoluteJump;
    logic       isLoad;
    logic       isStore;
    logic       unconditionalJump;
    logic       conditionalBranch;
    logic       branchEquals;

    modport decoder (
        output sourceReg1, sourceReg2, destReg,
        output immediate, immediateActive, functionCode,
        output isJal, relativeJump, absoluteJump,
        output isLoad, isStore,
        output unconditionalJump, conditionalBranch, branchEquals
    );

    // Operand side only needs sources, immediate and branch control.
    modport operands (
        input sourceReg1, sourceReg2,
        input immediate, immediateActive,
        input relativeJump, absoluteJump,
        input unconditionalJump, conditionalBranch, branchEquals
    );

endinterface

//--- src/regReadBus.sv
`timescale 1ns/1ps

interface regReadBus;
    import cpuPkg::*;

    regAddr_t readAddr1;
    regAddr_t readAddr2;
    word_t    readData1;
    word_t    readData2;

    modport reader (
        output readAddr1, readAddr2,
        input  readData1, readData2
    );

    modport file (
        input  readAddr1, readAddr2,
        output readData1, readData2
    );

endinterface

//--- src/instructionDecoder.sv
`timescale 1ns/1ps

module instructionDecoder (
    input  logic          Clock,
    input  logic          rst,
    input  cpuPkg::word_t instruction,
    input  logic          decodeStrobe,
    decodeBus.decoder     bus
);
    import cpuPkg::*;

    word_t       currentInstruction;

    opcode_t     opcode;
    format_t     format;
    category_t   category;
    logic [4:0]  destField;
    logic [4:0]  source1Field;
    logic [4:0]  source2Field;
    funct_t      functionField;
    logic [15:0] shortImmediate;
    immediate_t  longImmediate;
    logic [3:0]  floatOperation;

    logic        registerFormat;
    logic        jumpFormat;
    logic        immediateFormat;
    logic        floatRegister;
    logic        floatDestination;
    logic        memoryOrBranch;

    // Instruction register, held until the next strobe.
    always_ff @(posedge Clock) begin
        if (rst) begin
            currentInstruction <= '0;
        end else if (decodeStrobe) begin
            currentInstruction <= instruction;
        end
    end

    assign opcode         = currentInstruction[31:26];
    assign format         = currentInstruction[31:30];
    assign category       = currentInstruction[5:4];
    assign destField      = currentInstruction[25:21];
    assign source1Field   = currentInstruction[20:16];
    assign source2Field   = currentInstruction[15:11];
    assign functionField  = currentInstruction[5:0];
    assign shortImmediate = currentInstruction[15:0];
    assign longImmediate  = currentInstruction[25:0];
    assign floatOperation = currentInstruction[3:0];

    assign registerFormat  = (format == RegisterFormat);
    assign jumpFormat      = (format == JumpFormat);
    assign immediateFormat = isImmediateFormat(format);
    assign floatRegister   = registerFormat && (category == Float);

    // Float ops with low bits below 8 write a float result.
    assign floatDestination = (opcode == LoadFloatCode) || (opcode == StoreFloatCode)
                            || (floatRegister && (floatOperation < 4'd8));

    // Loads, stores, jumps and branches carry no ALU function.
    assign memoryOrBranch = (opcode >= LoadCode) && (opcode <= JalCode);

    assign bus.sourceReg1 = {floatRegister, source1Field};

    // Stores read their data register from the destination field.
    always_comb begin
        if (opcode == StoreCode) begin
            bus.sourceReg2 = intReg(destField);
        end else if (opcode == StoreFloatCode) begin
            bus.sourceReg2 = floatReg(destField);
        end else begin
            bus.sourceReg2 = {floatRegister, source2Field};
        end
    end

    always_comb begin
        if (floatDestination) begin
            bus.destReg = floatReg(destField);
        end else if (registerFormat || immediateFormat) begin
            bus.destReg = intReg(destField);
        end else begin
            bus.destReg = '0;
        end
    end

    always_comb begin
        if (jumpFormat) begin
            bus.immediate = longImmediate;
        end else if (immediateFormat) begin
            bus.immediate = {{10{shortImmediate[15]}}, shortImmediate};
        end else begin
            bus.immediate = '0;
        end
    end

    assign bus.immediateActive = jumpFormat || immediateFormat;

    always_comb begin
        if (registerFormat) begin
            bus.functionCode = functionField;
        end else if (jumpFormat || memoryOrBranch) begin
            bus.functionCode = '0;
        end else begin
            bus.functionCode = {1'b0, opcode[4:0]};
        end
    end

    assign bus.isJal        = (opcode == JalCode);
    assign bus.relativeJump = (opcode == JalCode) || (opcode == JumpCode)
                            || (opcode == BranchZeroCode) || (opcode == BranchNotZeroCode);
    assign bus.absoluteJump = (opcode == JumpRegCode);
    assign bus.isLoad       = (opcode == LoadCode) || (opcode == LoadFloatCode);
    assign bus.isStore      = (opcode == StoreCode) || (opcode == StoreFloatCode);

    assign bus.unconditionalJump = (opcode == JumpRegCode) || (opcode == JalCode)
                                 || (opcode == JumpCode);
    assign bus.conditionalBranch = (opcode == BranchZeroCode) || (opcode == BranchNotZeroCode);
    assign bus.branchEquals      = (opcode == BranchZeroCode);

endmodule

//--- src/registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic              Clock,
    input  logic              writeEnable,
    input  cpuPkg::regAddr_t  writeReg,
    input  cpuPkg::word_t     writeData,
    regReadBus.file           rd
);
    import cpuPkg::*;

    localparam int RegCount = 64;

    // Integer bank 0..31, float bank 32..63.
    word_t registers [RegCount];

    logic  writeAllowed;

    // Integer register 0 is hardwired to zero.
    assign writeAllowed = writeEnable && (writeReg != '0);

    always_ff @(posedge Clock) begin
        if (writeAllowed) begin
            registers[writeReg] <= writeData;
        end
    end

    always_comb begin
        if (rd.readAddr1 == '0) begin
            rd.readData1 = '0;
        end else begin
            rd.readData1 = registers[rd.readAddr1];
        end
    end

    always_comb begin
        if (rd.readAddr2 == '0) begin
            rd.readData2 = '0;
        end else begin
            rd.readData2 = registers[rd.readAddr2];
        end
    end

endmodule

//--- src/operandStage.sv
`timescale 1ns/1ps

module operandStage (
    input  cpuPkg::word_t pc,
    decodeBus.operands    bus,
    regReadBus.reader     rd,
    output cpuPkg::word_t operandA,
    output cpuPkg::word_t operandB,
    output cpuPkg::word_t storeData,
    output cpuPkg::word_t jumpTarget,
    output logic          branchTaken
);
    import cpuPkg::*;

    word_t extendedImmediate;
    word_t relativeTarget;
    logic  operandAZero;
    logic  conditionMet;

    assign rd.readAddr1 = bus.sourceReg1;
    assign rd.readAddr2 = bus.sourceReg2;

    // Sign extension from bit 25 covers both immediate forms.
    assign extendedImmediate = {{6{bus.immediate[25]}}, bus.immediate};

    assign operandA  = rd.readData1;
    assign operandB  = bus.immediateActive ? extendedImmediate : rd.readData2;
    assign storeData = rd.readData2;

    assign operandAZero = (rd.readData1 == '0);

    // BEQZ-style when branchEquals, BNEZ-style otherwise.
    always_comb begin
        if (bus.branchEquals) begin
            conditionMet = operandAZero;
        end else begin
            conditionMet = !operandAZero;
        end
    end

    // Conditional branches are always PC relative.
    assign branchTaken = bus.unconditionalJump
                       || (bus.conditionalBranch && bus.relativeJump && conditionMet);

    assign relativeTarget = pc + 32'd4 + extendedImmediate;

    always_comb begin
        if (bus.absoluteJump) begin
            jumpTarget = rd.readData1;
        end else begin
            jumpTarget = relativeTarget;
        end
    end

endmodule

//--- src/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
    input  logic             Clock,
    input  logic             rst,
    input  cpuPkg::word_t    instruction,
    input  logic             decodeStrobe,
    input  cpuPkg::word_t    pc,
    input  logic             writeEnable,
    input  cpuPkg::regAddr_t writeReg,
    input  cpuPkg::word_t    writeData,
    output cpuPkg::word_t    operandA,
    output cpuPkg::word_t    operandB,
    output cpuPkg::word_t    storeData,
    output cpuPkg::word_t    jumpTarget,
    output cpuPkg::regAddr_t destReg,
    output cpuPkg::funct_t   functionCode,
    output logic             isLoad,
    output logic             isStore,
    output logic             isJal,
    output logic             branchTaken
);

    decodeBus  decoded ();
    regReadBus readPorts ();

    instructionDecoder decoder (
        .Clock        (Clock),
        .rst          (rst),
        .instruction  (instruction),
        .decodeStrobe (decodeStrobe),
        .bus          (decoded.decoder)
    );

    registerFile regs (
        .Clock       (Clock),
        .writeEnable (writeEnable),
        .writeReg    (writeReg),
        .writeData   (writeData),
        .rd          (readPorts.file)
    );

    operandStage operands (
        .pc          (pc),
        .bus         (decoded.operands),
        .rd          (readPorts.reader),
        .operandA    (operandA),
        .operandB    (operandB),
        .storeData   (storeData),
        .jumpTarget  (jumpTarget),
        .branchTaken (branchTaken)
    );

    // Decoded fields passed on to later stages.
    assign destReg      = decoded.destReg;
    assign functionCode = decoded.functionCode;
    assign isLoad       = decoded.isLoad;
    assign isStore      = decoded.isStore;
    assign isJal        = decoded.isJal;

endmodule

//--- tb/decodeStageAssertions.sv
`timescale 1ns/1ps

module decodeStageAssertions (
    input logic             Clock,
    input logic             rst,
    input logic             decodeStrobe,
    input logic             writeEnable,
    input cpuPkg::word_t    operandA,
    input cpuPkg::word_t    operandB,
    input cpuPkg::word_t    storeData,
    input cpuPkg::regAddr_t destReg,
    input cpuPkg::funct_t   functionCode,
    input logic             isLoad,
    input logic             isStore,
    input logic             isJal,
    input logic             branchTaken
);
    int exclusiveFailures = 0;
    int resetFailures = 0;
    int holdFailures = 0;
    int failureCount;

    logic [111:0] heldOutputs;

    // Everything here is a function of the latched instruction and the registers.
    assign heldOutputs = {operandA, operandB, storeData, destReg, functionCode,
                          isLoad, isStore, isJal, branchTaken};

    assign failureCount = exclusiveFailures + resetFailures + holdFailures;

    loadStoreExclusive: assert property (@(posedge Clock) disable iff (rst)
        !(isLoad && isStore))
    else begin
        exclusiveFailures++;
        $error("isLoad and isStore are high together");
    end

    // Reset clears the instruction, so nothing is taken afterwards.
    noBranchAfterReset: assert property (@(posedge Clock) rst |=> !branchTaken)
    else begin
        resetFailures++;
        $error("branchTaken is high right after reset");
    end

    outputsHeld: assert property (@(posedge Clock) disable iff (rst)
        (!decodeStrobe && !writeEnable) |=> $stable(heldOutputs))
    else begin
        holdFailures++;
        $error("outputs changed without a strobe or a register write");
    end

endmodule

bind decodeStage decodeStageAssertions assertionChecks (.*);

//--- tb/decodeStageTb.sv
`timescale 1ns/1ps

module decodeStageTb;
    import cpuPkg::*;

    localparam int ClockPeriod = 8;
    // About 30 cycles of tests and a wide margin.
    localparam int TimeoutCycles = 400;

    logic     Clock;
    logic     rst;
    word_t    instruction;
    logic     decodeStrobe;
    word_t    pc;
    logic     writeEnable;
    regAddr_t writeReg;
    word_t    writeData;
    word_t    operandA;
    word_t    operandB;
    word_t    storeData;
    word_t    jumpTarget;
    regAddr_t destReg;
    funct_t   functionCode;
    logic     isLoad;
    logic     isStore;
    logic     isJal;
    logic     branchTaken;

    word_t    lfsrState;
    word_t    expectedRegs [64];
    int       cycleCount = 0;

    decodeStage uut (.*);

    initial begin
        Clock = 1'b0;
        forever #(ClockPeriod / 2) Clock = ~Clock;
    end

    always @(posedge Clock) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("timeout: the tests did not finish within %0d cycles", TimeoutCycles);
            $display("Test FAILED");
            $fatal(1, "simulation timeout");
        end
    end

    // Galois form of x^32 + x^22 + x^2 + x + 1.
    function automatic word_t stepLfsr(input word_t state);
        word_t next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h8020_0003;
        end
        return next;
    endfunction

    task automatic randomWord(output word_t value);
        value = '0;
        for (int i = 0; i < 32; i++) begin
            value = {value[30:0], lfsrState[0]};
            lfsrState = stepLfsr(lfsrState);
        end
    endtask

    task automatic checkValue(input string testName, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("error %s expected %h actual %h", testName, expected, actual);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic word_t signExtend16(input logic [15:0] value);
        return {{16{value[15]}}, value};
    endfunction

    function automatic word_t signExtend26(input logic [25:0] value);
        return {{6{value[25]}}, value};
    endfunction

    function automatic word_t regOp(input logic [4:0] dest, input logic [4:0] src1,
                                    input logic [4:0] src2, input funct_t funct);
        return {6'b000000, dest, src1, src2, 5'b00000, funct};
    endfunction

    function automatic word_t immOp(input opcode_t op, input logic [4:0] dest,
                                    input logic [4:0] src1, input logic [15:0] imm);
        return {op, dest, src1, imm};
    endfunction

    task automatic nextCycle();
        @(posedge Clock);
        #1;
    endtask

    task automatic writeRegister(input regAddr_t addr, input word_t data);
        writeEnable = 1'b1;
        writeReg = addr;
        writeData = data;
        nextCycle();
        writeEnable = 1'b0;
        // Integer register 0 stays zero.
        if (addr != '0) begin
            expectedRegs[addr] = data;
        end
    endtask

    task automatic writeRandom(input regAddr_t addr);
        word_t data;
        randomWord(data);
        writeRegister(addr, data);
    endtask

    // Outputs are valid right after the strobed edge.
    task automatic decode(input word_t instr);
        instruction = instr;
        decodeStrobe = 1'b1;
        nextCycle();
        decodeStrobe = 1'b0;
    endtask

    task automatic resetTest();
        nextCycle();
        checkValue("reset flags", '0, word_t'({isLoad, isStore, isJal, branchTaken}));
        checkValue("reset functionCode", '0, word_t'(functionCode));
    endtask

    task automatic intRegTest();
        writeRandom(6'd3);
        writeRandom(6'd7);
        writeRegister(6'd0, 32'hDEAD_BEEF);
        decode(regOp(5'd5, 5'd3, 5'd7, 6'h0A));
        checkValue("int operandA", expectedRegs[3], operandA);
        checkValue("int operandB", expectedRegs[7], operandB);
        checkValue("int destReg", 32'd5, word_t'(destReg));
        checkValue("int functionCode", 32'h0A, word_t'(functionCode));
        decode(regOp(5'd1, 5'd0, 5'd7, 6'h01));
        checkValue("register zero", 32'd0, operandA);
    endtask

    task automatic floatRegTest();
        writeRandom(6'd36);
        writeRandom(6'd41);
        writeRandom(6'd4);
        // Category 2 with low bits 3 writes float register 6.
        decode(regOp(5'd6, 5'd4, 5'd9, 6'b10_0011));
        checkValue("float operandA", expectedRegs[36], operandA);
        checkValue("float operandB", expectedRegs[41], operandB);
        checkValue("float destReg", 32'd38, word_t'(destReg));
        decode(regOp(5'd6, 5'd4, 5'd9, 6'b10_1010));
        checkValue("float int destReg", 32'd6, word_t'(destReg));
    endtask

    task automatic immediateTest();
        decode(immOp(6'b100011, 5'd8, 5'd3, 16'hFF9C));
        checkValue("alu imm operandA", expectedRegs[3], operandA);
        checkValue("alu imm operandB", signExtend16(16'hFF9C), operandB);
        checkValue("alu imm functionCode", 32'h03, word_t'(functionCode));
        checkValue("alu imm destReg", 32'd8, word_t'(destReg));
        decode(immOp(LoadCode, 5'd10, 5'd7, 16'h0010));
        checkValue("load flags", 32'b10, word_t'({isLoad, isStore}));
        checkValue("load destReg", 32'd10, word_t'(destReg));
        checkValue("load functionCode", 32'd0, word_t'(functionCode));
        decode(immOp(StoreFloatCode, 5'd4, 5'd3, 16'h0008));
        checkValue("float store flags", 32'b01, word_t'({isLoad, isStore}));
        checkValue("float store data", expectedRegs[36], storeData);
        checkValue("float store operandB", 32'd8, operandB);
    endtask

    task automatic branchTest();
        pc = 32'h0000_1000;
        decode(immOp(BranchZeroCode, 5'd0, 5'd0, 16'h0020));
        checkValue("beqz zero", 32'd1, word_t'(branchTaken));
        checkValue("beqz target", pc + 32'd4 + signExtend16(16'h0020), jumpTarget);
        decode(immOp(BranchZeroCode, 5'd0, 5'd3, 16'h0020));
        checkValue("beqz nonzero", word_t'(expectedRegs[3] == '0), word_t'(branchTaken));
        decode(immOp(BranchNotZeroCode, 5'd0, 5'd3, 16'hFFF0));
        checkValue("bnez nonzero", word_t'(expectedRegs[3] != '0), word_t'(branchTaken));
        decode(immOp(BranchNotZeroCode, 5'd0, 5'd0, 16'hFFF0));
        checkValue("bnez zero", 32'd0, word_t'(branchTaken));
        decode({JumpCode, 26'h3FF_FFF0});
        checkValue("j target", pc + 32'd4 + signExtend26(26'h3FF_FFF0), jumpTarget);
        checkValue("j flags", 32'b01, word_t'({isJal, branchTaken}));
        decode(immOp(JalCode, 5'd0, 5'd0, 16'h0100));
        checkValue("jal target", pc + 32'd4 + signExtend16(16'h0100), jumpTarget);
        checkValue("jal flags", 32'b11, word_t'({isJal, branchTaken}));
        decode(immOp(JumpRegCode, 5'd0, 5'd7, 16'h0000));
        checkValue("jr target", expectedRegs[7], jumpTarget);
        checkValue("jr taken", 32'd1, word_t'(branchTaken));
    endtask

    task automatic holdTest();
        decode(regOp(5'd5, 5'd3, 5'd7, 6'h0A));
        instruction = immOp(LoadCode, 5'd12, 5'd4, 16'h0004);
        repeat (3) nextCycle();
        checkValue("hold operandA", expectedRegs[3], operandA);
        checkValue("hold operandB", expectedRegs[7], operandB);
        checkValue("hold storeData", expectedRegs[7], storeData);
        checkValue("hold destReg", 32'd5, word_t'(destReg));
        checkValue("hold functionCode", 32'h0A, word_t'(functionCode));
        checkValue("hold flags", 32'd0, word_t'({isLoad, isStore, isJal, branchTaken}));
    endtask

    initial begin
        rst = 1'b1;
        instruction = '0;
        decodeStrobe = 1'b0;
        pc = '0;
        writeEnable = 1'b0;
        writeReg = '0;
        writeData = '0;
        lfsrState = 32'd95;
        expectedRegs[0] = '0;
        repeat (2) @(posedge Clock);
        #1;
        rst = 1'b0;
        resetTest();
        intRegTest();
        floatRegTest();
        immediateTest();
        branchTest();
        holdTest();
        // One more edge so the last hold check completes.
        nextCycle();
        if (uut.assertionChecks.failureCount == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("%0d assertion failures", uut.assertionChecks.failureCount);
            $display("Test FAILED");
            $fatal(1, "assertion failures");
        end
    end

endmodule

//--- filelist.f
src/cpuPkg.sv
src/decodeBus.sv
src/regReadBus.sv
src/instructionDecoder.sv
src/registerFile.sv
src/operandStage.sv
src/decodeStage.sv
tb/decodeStageAssertions.sv
tb/decodeStageTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= decodeStageTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Test OK
VFLAGS    ?= --binary --timing --assert
RUNFLAGS  ?= +verilator+error+limit+100

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BINARY) $(RUNFLAGS) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
